// File: bench/ddr_ctrl_props.sv
//--------------------
// Bound checks on the DDR controller
// Credits, CKE gating and the FML done pulse
//--------------------
`timescale 1ns/1ps

module ddr_ctrl_props #(
	parameter int CMD_DEPTH = 4
) (
	input logic                           clk,
	input logic                           reset_int,
	input logic                           fml_done_i,
	input ddr_pkg::ddr_pins_t             pins_i,
	input logic [$clog2(CMD_DEPTH+1)-1:0] credit_cnt_i
);
	import ddr_pkg::*;

	// Credits only return for popped commands
	credit_max: assert property (@(posedge clk) disable iff (reset_int)
		int'(credit_cnt_i) <= CMD_DEPTH)
		else $error("Credit count %0d above queue depth %0d", credit_cnt_i, CMD_DEPTH);

	// Nothing but NOP with the clock disabled
	cke_nop: assert property (@(posedge clk) disable iff (reset_int)
		!pins_i.cke |-> ({pins_i.ras_n, pins_i.cas_n, pins_i.we_n} == NOP))
		else $error("Command on the pins while CKE is low");

	// Single-cycle done
	done_pulse: assert property (@(posedge clk) disable iff (reset_int)
		fml_done_i |=> !fml_done_i)
		else $error("fml_done_o high for two cycles");

endmodule

bind ddr_ctrl ddr_ctrl_props #(
	.CMD_DEPTH(CMD_DEPTH)
) u_props (
	.clk         (clk),
	.reset_int   (reset_int),
	.fml_done_i  (fml_done_o),
	.pins_i      (pins_o),
	.credit_cnt_i(u_sched.credit_cnt)
);

// File: bench/tb_ddr_ctrl.sv
//--------------------
// Testbench for the DDR command controller
// Random FML requests checked against a bank model
//--------------------
`timescale 1ns/1ps

module tb_ddr_ctrl;
	import ddr_pkg::*;

	localparam int WAIT_INIT      = 20;
	localparam int REFRESH_PERIOD = 300;
	localparam int CMD_DEPTH      = 4;
	localparam int CMD_GAP        = 2;
	localparam int N_REQ          = 200;
	localparam int N_BANKS        = 1 << BA_W;
	localparam int CYCLE_LIMIT    = N_REQ * 40 + WAIT_INIT + 200;

	logic      clk = 1'b0;
	logic      reset_int;
	fml_req_t  fml_req;
	logic      fml_done;
	ddr_pins_t pins;

	// Requests in flight, oldest first
	fml_req_t req_q [$];
	// Remaining commands of the oldest request
	ddr_cba_t exp_q [$];

	// Bank table of the model
	logic [ROW_W-1:0]   model_row [N_BANKS];
	logic [N_BANKS-1:0] model_act;

	int          cyc = 0;
	int          last_cmd_cyc;
	int          init_idx;
	int          done_cnt;
	int          ar_pairs;
	logic        ar_pending;
	logic [31:0] rng;

	ddr_ctrl #(
		.WAIT_INIT     (WAIT_INIT),
		.REFRESH_PERIOD(REFRESH_PERIOD),
		.CMD_DEPTH     (CMD_DEPTH),
		.CMD_GAP       (CMD_GAP)
	) UUT (
		.clk       (clk),
		.reset_int (reset_int),
		.fml_req_i (fml_req),
		.fml_done_o(fml_done),
		.pins_o    (pins)
	);

	always #50 clk = ~clk;

	//--------------------
	// Helpers
	//--------------------
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "Run stopped at cycle %0d", cyc);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Power-up commands in DRAM order
	function automatic ddr_cba_t init_cmd(input int idx);
		ddr_cba_t c;
		c.cmd = AR;
		c.ba  = '0;
		c.a   = '0;
		if (idx == 0) begin
			c.cmd        = PRE;
			c.a[A10_ALL] = 1'b1;
		end else if (idx == 3) begin
			c.cmd = MRS;
			c.a   = MODE_WORD;
		end
		return c;
	endfunction

	// Reference: commands one request needs, given the bank table
	function automatic void expected_cmds(input fml_req_t r);
		logic [BA_W-1:0]  ba;
		logic [ROW_W-1:0] row;
		logic [COL_W-1:0] col;
		ddr_cba_t         c;
		ba  = r.adr[ADR_W-1 -: BA_W];
		row = r.adr[COL_W +: ROW_W];
		col = r.adr[COL_W-1:0];
		exp_q.delete();
		c.ba = ba;
		// Wrong row open, close it first
		if (model_act[ba] && model_row[ba] != row) begin
			c.cmd = PRE;
			c.a   = '0;
			exp_q.push_back(c);
		end
		if (!model_act[ba] || model_row[ba] != row) begin
			c.cmd = ACT;
			c.a   = row;
			exp_q.push_back(c);
		end
		if (r.wr)
			c.cmd = WRITE;
		else
			c.cmd = READ;
		// Column sits on a[9:3]
		c.a = ROW_W'({col, 3'b000});
		exp_q.push_back(c);
	endfunction

	// One non-NOP command off the pins
	task automatic check_command(input ddr_cba_t got);
		ddr_cba_t exp;
		if (init_idx < 4) begin
			exp = init_cmd(init_idx);
			assert (got == exp) else
				report_failure($sformatf("Mismatch pins_o init cmd: got %h expected %h",
					got, exp));
			init_idx++;
		end else if (ar_pending) begin
			assert (got.cmd == AR) else
				report_failure($sformatf("Mismatch pins_o.cmd after PRE-all: got %h expected %h",
					got.cmd, AR));
			ar_pending = 1'b0;
			ar_pairs++;
		end else if (got.cmd == PRE && got.a[A10_ALL]) begin
			// Refresh closes all banks, rest of the request is rebuilt
			ar_pending = 1'b1;
			model_act  = '0;
			exp_q.delete();
		end else begin
			if (exp_q.size() == 0) begin
				assert (req_q.size() != 0) else
					report_failure("Command on the pins with no request outstanding");
				expected_cmds(req_q[0]);
			end
			exp = exp_q.pop_front();
			assert (got == exp) else
				report_failure($sformatf("Mismatch pins_o cmd/ba/a: got %h expected %h",
					got, exp));
			case (got.cmd)
				ACT: begin
					model_act[got.ba] = 1'b1;
					model_row[got.ba] = got.a;
				end
				PRE: model_act[got.ba] = 1'b0;
				// READ or WRITE ends the request
				default: req_q.delete(0);
			endcase
		end
	endtask

	//--------------------
	// Cycle count and timeout
	//--------------------
	always @(posedge clk) begin
		if (reset_int)
			cyc <= 0;
		else
			cyc <= cyc + 1;
		if (cyc >= CYCLE_LIMIT)
			report_failure($sformatf("Timeout after %0d cycles with %0d requests open",
				cyc, req_q.size()));
	end

	//--------------------
	// Monitor, samples on the falling edge
	//--------------------
	always @(negedge clk) begin
		ddr_cba_t got;
		got.cmd = ddr_cmd_e'({pins.ras_n, pins.cas_n, pins.we_n});
		got.ba  = pins.ba;
		got.a   = pins.a;
		if (reset_int) begin
			assert (got.cmd == NOP && !pins.cke) else
				report_failure("Command or CKE active during reset");
		end else begin
			// cke_o after WAIT_INIT cycles, one more register to the pins
			assert (pins.cke == (cyc > WAIT_INIT)) else
				report_failure($sformatf("Mismatch pins_o.cke: got %h expected %h at cycle %0d",
					pins.cke, cyc > WAIT_INIT, cyc));
			assert (!pins.cs_n) else
				report_failure("Mismatch pins_o.cs_n: got 1 expected 0");
			assert (pins.cke || got.cmd == NOP) else
				report_failure("Command issued while CKE is low");
			if (got.cmd != NOP) begin
				assert (last_cmd_cyc < 0 || cyc - last_cmd_cyc >= CMD_GAP) else
					report_failure($sformatf("Commands only %0d cycles apart, minimum %0d",
						cyc - last_cmd_cyc, CMD_GAP));
				last_cmd_cyc = cyc;
				check_command(got);
			end
			if (fml_done)
				done_cnt++;
		end
	end

	//--------------------
	// Stimulus
	//--------------------
	initial begin
		fml_req_t req;
		int       idle;
		int       i;
		reset_int    = 1'b1;
		fml_req      = '0;
		rng          = 32'd27;
		last_cmd_cyc = -1;
		init_idx     = 0;
		done_cnt     = 0;
		ar_pairs     = 0;
		ar_pending   = 1'b0;
		model_act    = '0;
		repeat (2) @(negedge clk);
		reset_int = 1'b0;

		for (i = 0; i < N_REQ; i++) begin
			rng     = xorshift32(rng);
			idle    = int'(rng[9:8]);
			fml_req = '0;
			repeat (idle) @(negedge clk);
			// Two row bits only, hits and misses both common
			req.rd  = ~rng[31];
			req.wr  = rng[31];
			req.adr = {rng[1:0], rng[3], 10'd0, rng[2], 1'b1, rng[22:16]};
			req_q.push_back(req);
			fml_req = req;
			// Held until done
			@(negedge clk);
			while (!fml_done)
				@(negedge clk);
		end
		fml_req = '0;

		// Drain the issue queue
		while (req_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		assert (done_cnt == N_REQ) else
			report_failure($sformatf("Mismatch fml_done_o pulse count: got %h expected %h",
				done_cnt, N_REQ));
		if (ar_pairs > 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			report_failure("No refresh pair seen during the run");
		end
	end

endmodule

// File: list.f
rtl/ddr_pkg.sv
rtl/ddr_init.sv
rtl/ddr_refresh_timer.sv
rtl/ddr_sched.sv
rtl/ddr_cmd_issue.sv
rtl/ddr_ctrl.sv
bench/ddr_ctrl_props.sv
bench/tb_ddr_ctrl.sv

// File: rtl/ddr_cmd_issue.sv
//--------------------
// DDR command issue stage
// Queue with spaced pops onto the command pins,
// one credit back per popped command
//--------------------
`timescale 1ns/1ps

module ddr_cmd_issue #(
	parameter int CMD_DEPTH = 4,
	parameter int CMD_GAP   = 2
) (
	input  logic               clk,
	input  logic               reset_int,
	input  logic               cmd_valid_i,
	input  ddr_pkg::ddr_cba_t  cmd_i,
	input  logic               cke_i,
	output logic               credit_o,
	output ddr_pkg::ddr_pins_t pins_o
);
	import ddr_pkg::*;

	localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
	localparam int CNT_W = $clog2(CMD_DEPTH + 1);
	localparam int GAP_W = (CMD_GAP > 1) ? $clog2(CMD_GAP) : 1;

	ddr_cba_t         q_mem [CMD_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] q_cnt;
	logic [GAP_W-1:0] gap_cnt;
	logic             pop;
	ddr_cba_t         head;

	// Circular pointer step
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(CMD_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	//--------------------
	// Queue
	//--------------------
	assign head = q_mem[rd_ptr];

	// Pop once the gap has run out, never with CKE low
	assign pop = cke_i && (q_cnt != '0) && (gap_cnt == '0);

	always_ff @(posedge clk) begin
		if (reset_int) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			q_cnt    <= '0;
			gap_cnt  <= '0;
			credit_o <= 1'b0;
		end else begin
			if (cmd_valid_i)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			q_cnt <= q_cnt + CNT_W'(cmd_valid_i) - CNT_W'(pop);

			// Reload on pop, then count down
			if (pop)
				gap_cnt <= GAP_W'(CMD_GAP - 1);
			else if (gap_cnt != '0)
				gap_cnt <= gap_cnt - 1'b1;

			// Slot freed
			credit_o <= pop;
		end
	end

	// Credits keep the writer from overrunning the queue
	always_ff @(posedge clk) begin
		if (cmd_valid_i)
			q_mem[wr_ptr] <= cmd_i;
	end

	//--------------------
	// Pin register
	//--------------------
	always_ff @(posedge clk) begin
		if (reset_int) begin
			pins_o.cke   <= 1'b0;
			pins_o.cs_n  <= 1'b0;
			pins_o.ras_n <= 1'b1;
			pins_o.cas_n <= 1'b1;
			pins_o.we_n  <= 1'b1;
			pins_o.ba    <= '0;
			pins_o.a     <= '0;
		end else begin
			pins_o.cke  <= cke_i;
			pins_o.cs_n <= 1'b0;
			if (pop) begin
				// Opcode bits are the ras/cas/we levels
				{pins_o.ras_n, pins_o.cas_n, pins_o.we_n} <= head.cmd;
				pins_o.ba <= head.ba;
				pins_o.a  <= head.a;
			end else begin
				// Idle slot, address lines keep their value
				{pins_o.ras_n, pins_o.cas_n, pins_o.we_n} <= NOP;
			end
		end
	end

endmodule

// File: rtl/ddr_ctrl.sv
//--------------------
// DDR controller, command side
// Init, refresh, scheduling and issue on one clock
//--------------------
`timescale 1ns/1ps

module ddr_ctrl #(
	parameter int WAIT_INIT      = 20,
	parameter int REFRESH_PERIOD = 300,
	parameter int CMD_DEPTH      = 4,
	parameter int CMD_GAP        = 2
) (
	input  logic               clk,
	input  logic               reset_int,
	input  ddr_pkg::fml_req_t  fml_req_i,
	output logic               fml_done_o,
	output ddr_pkg::ddr_pins_t pins_o
);
	import ddr_pkg::*;

	// Init handshake
	logic     init_req;
	logic     init_ack;
	logic     init_done;
	ddr_cba_t init_cba;
	logic     cke;

	// Refresh handshake
	logic ar_req;
	logic ar_done;

	// Scheduler to issue stage
	logic     cmd_valid;
	ddr_cba_t cmd;
	logic     credit;

	//--------------------
	// Power-up and refresh
	//--------------------
	ddr_init #(
		.WAIT_INIT(WAIT_INIT)
	) u_init (
		.clk        (clk),
		.reset_int  (reset_int),
		.init_ack_i (init_ack),
		.init_req_o (init_req),
		.init_cba_o (init_cba),
		.init_done_o(init_done),
		.cke_o      (cke)
	);

	ddr_refresh_timer #(
		.REFRESH_PERIOD(REFRESH_PERIOD)
	) u_refresh (
		.clk      (clk),
		.reset_int(reset_int),
		.ar_done_i(ar_done),
		.ar_req_o (ar_req)
	);

	//--------------------
	// Scheduler and issue
	//--------------------
	ddr_sched #(
		.CMD_DEPTH(CMD_DEPTH)
	) u_sched (
		.clk        (clk),
		.reset_int  (reset_int),
		.fml_req_i  (fml_req_i),
		.fml_done_o (fml_done_o),
		.init_req_i (init_req),
		.init_cba_i (init_cba),
		.init_done_i(init_done),
		.init_ack_o (init_ack),
		.ar_req_i   (ar_req),
		.ar_done_o  (ar_done),
		.credit_i   (credit),
		.cmd_valid_o(cmd_valid),
		.cmd_o      (cmd)
	);

	ddr_cmd_issue #(
		.CMD_DEPTH(CMD_DEPTH),
		.CMD_GAP  (CMD_GAP)
	) u_issue (
		.clk        (clk),
		.reset_int  (reset_int),
		.cmd_valid_i(cmd_valid),
		.cmd_i      (cmd),
		.cke_i      (cke),
		.credit_o   (credit),
		.pins_o     (pins_o)
	);

endmodule

// File: rtl/ddr_init.sv
//--------------------
// DDR power-up sequencer
// Holds CKE low for the wait period, then hands the
// PRE-all, AR, AR, MRS sequence to the scheduler
//--------------------
`timescale 1ns/1ps

module ddr_init #(
	parameter int WAIT_INIT = 20
) (
	input  logic              clk,
	input  logic              reset_int,
	input  logic              init_ack_i,
	output logic              init_req_o,
	output ddr_pkg::ddr_cba_t init_cba_o,
	output logic              init_done_o,
	output logic              cke_o
);
	import ddr_pkg::*;

	localparam int WAIT_W = $clog2(WAIT_INIT + 1);

	// Step of the MRS, last one in the sequence
	localparam logic [1:0] LAST_STEP = 2'd3;

	logic [WAIT_W-1:0] wait_cnt;
	logic [1:0]        step;

	//--------------------
	// Wait counter and step counter
	//--------------------
	always_ff @(posedge clk) begin
		if (reset_int) begin
			wait_cnt    <= '0;
			cke_o       <= 1'b0;
			step        <= '0;
			init_done_o <= 1'b0;
		end else begin
			// CKE rises after WAIT_INIT clocks and stays up
			if (!cke_o) begin
				if (wait_cnt == WAIT_W'(WAIT_INIT - 1))
					cke_o <= 1'b1;
				else
					wait_cnt <= wait_cnt + 1'b1;
			end

			// Advance on each ack, next command shows a cycle later
			if (init_req_o && init_ack_i) begin
				if (step == LAST_STEP)
					init_done_o <= 1'b1;
				else
					step <= step + 1'b1;
			end
		end
	end

	// Only ask once the clock is enabled
	assign init_req_o = cke_o & ~init_done_o;

	//--------------------
	// Command of the current step
	//--------------------
	always_comb begin
		init_cba_o.cmd = NOP;
		init_cba_o.ba  = '0;
		init_cba_o.a   = '0;
		case (step)
			2'd0: begin
				// Close everything first
				init_cba_o.cmd        = PRE;
				init_cba_o.a[A10_ALL] = 1'b1;
			end
			2'd1,
			2'd2: begin
				// Two refresh cycles
				init_cba_o.cmd = AR;
			end
			default: begin
				init_cba_o.cmd = MRS;
				init_cba_o.a   = MODE_WORD;
			end
		endcase
	end

endmodule

// File: rtl/ddr_pkg.sv
//--------------------
// DDR controller shared definitions
// Command opcodes, scheduler states, bundles and address fields
//--------------------
package ddr_pkg;

	//--------------------
	// Address fields
	//--------------------
	// Bank on top, then row, then column
	localparam int BA_W  = 2;
	localparam int ROW_W = 13;
	localparam int COL_W = 7;
	localparam int ADR_W = BA_W + ROW_W + COL_W;

	// A10 high on PRE closes every bank
	localparam int A10_ALL = 10;

	// CAS latency 2, sequential burst of 4
	localparam logic [ROW_W-1:0] MODE_WORD = 13'h0022;

	//--------------------
	// Opcodes and states
	//--------------------
	// Encoded as {ras_n, cas_n, we_n} from the DDR truth table
	typedef enum logic [2:0] {
		MRS   = 3'b000,
		AR    = 3'b001,
		PRE   = 3'b010,
		ACT   = 3'b011,
		WRITE = 3'b100,
		READ  = 3'b101,
		NOP   = 3'b111
	} ddr_cmd_e;

	typedef enum logic [1:0] {
		S_INIT = 2'd0,
		S_IDLE = 2'd1,
		S_AR   = 2'd2
	} sched_state_e;

	//--------------------
	// Bundles
	//--------------------
	// One queued command, 18 bits
	// Address bus is as wide as a row
	typedef struct packed {
		ddr_cmd_e         cmd;
		logic [BA_W-1:0]  ba;
		logic [ROW_W-1:0] a;
	} ddr_cba_t;

	// Command pins toward the DRAM
	typedef struct packed {
		logic             cke;
		logic             cs_n;
		logic             ras_n;
		logic             cas_n;
		logic             we_n;
		logic [BA_W-1:0]  ba;
		logic [ROW_W-1:0] a;
	} ddr_pins_t;

	// FML request, held until done
	typedef struct packed {
		logic             rd;
		logic             wr;
		logic [ADR_W-1:0] adr;
	} fml_req_t;

endpackage

// File: rtl/ddr_refresh_timer.sv
//--------------------
// Auto-refresh timer
// Periodic pulse with a sticky request until served
//--------------------
`timescale 1ns/1ps

module ddr_refresh_timer #(
	parameter int REFRESH_PERIOD = 300
) (
	input  logic clk,
	input  logic reset_int,
	input  logic ar_done_i,
	output logic ar_req_o
);

	localparam int CNT_W = $clog2(REFRESH_PERIOD);

	logic [CNT_W-1:0] period_cnt;
	logic             ar_pulse;

	// Last count of the period
	assign ar_pulse = (period_cnt == CNT_W'(REFRESH_PERIOD - 1));

	always_ff @(posedge clk) begin
		if (reset_int) begin
			period_cnt <= '0;
			ar_req_o   <= 1'b0;
		end else begin
			// Wrapping period counter
			if (ar_pulse)
				period_cnt <= '0;
			else
				period_cnt <= period_cnt + 1'b1;

			// Set by the pulse, held until the scheduler takes it
			ar_req_o <= ar_pulse | (ar_req_o & ~ar_done_i);
		end
	end

endmodule

// File: rtl/ddr_sched.sv
//--------------------
// DDR command scheduler
// Tracks open rows per bank and turns init, refresh and
// FML requests into commands, gated by issue credits
//--------------------
`timescale 1ns/1ps

module ddr_sched #(
	parameter int CMD_DEPTH = 4
) (
	input  logic              clk,
	input  logic              reset_int,
	// FML side
	input  ddr_pkg::fml_req_t fml_req_i,
	output logic              fml_done_o,
	// Init sequencer
	input  logic              init_req_i,
	input  ddr_pkg::ddr_cba_t init_cba_i,
	input  logic              init_done_i,
	output logic              init_ack_o,
	// Refresh timer
	input  logic              ar_req_i,
	output logic              ar_done_o,
	// Issue stage
	input  logic              credit_i,
	output logic              cmd_valid_o,
	output ddr_pkg::ddr_cba_t cmd_o
);
	import ddr_pkg::*;

	localparam int CRD_W   = $clog2(CMD_DEPTH + 1);
	localparam int N_BANKS = 1 << BA_W;
	// Zero bits above the column on READ/WRITE
	localparam int COL_HI  = ROW_W - COL_W - 3;

	sched_state_e     state;
	sched_state_e     state_nxt;
	logic [CRD_W-1:0] credit_cnt;
	logic             have_credit;

	// Open row per bank
	logic [ROW_W-1:0]   bank_row [N_BANKS];
	logic [N_BANKS-1:0] bank_act;

	// Request decode
	logic [BA_W-1:0]  req_ba;
	logic [ROW_W-1:0] req_row;
	logic [COL_W-1:0] req_col;
	logic             req_any;
	logic             row_open;
	logic             row_hit;

	// Decision of this cycle
	ddr_cba_t cmd_nxt;
	logic     take;
	logic     take_init;
	logic     take_rw;
	logic     take_ar;
	logic     take_pre;
	logic     take_act;

	//--------------------
	// FML decode
	//--------------------
	assign req_ba  = fml_req_i.adr[ADR_W-1 -: BA_W];
	assign req_row = fml_req_i.adr[COL_W +: ROW_W];
	assign req_col = fml_req_i.adr[0 +: COL_W];

	// Request still pending, blank in the done cycle
	assign req_any  = (fml_req_i.rd | fml_req_i.wr) & ~fml_done_o;
	assign row_open = bank_act[req_ba];
	assign row_hit  = row_open & (bank_row[req_ba] == req_row);

	assign have_credit = (credit_cnt != '0);

	//--------------------
	// Next command
	//--------------------
	always_comb begin
		state_nxt   = state;
		cmd_nxt.cmd = NOP;
		cmd_nxt.ba  = '0;
		cmd_nxt.a   = '0;
		take_init   = 1'b0;
		take_rw     = 1'b0;
		take_ar     = 1'b0;
		take_pre    = 1'b0;
		take_act    = 1'b0;
		case (state)
			S_INIT: begin
				// Skip the ack cycle, init shows its next step after it
				if (init_req_i && !init_ack_o && have_credit) begin
					take_init = 1'b1;
					cmd_nxt   = init_cba_i;
				end
				if (init_done_i)
					state_nxt = S_IDLE;
			end
			S_IDLE: begin
				if (have_credit) begin
					if (req_any && row_hit) begin
						// Row hit, column in bits 9:3
						take_rw    = 1'b1;
						cmd_nxt.ba = req_ba;
						cmd_nxt.a  = {{COL_HI{1'b0}}, req_col, 3'b000};
						if (fml_req_i.wr)
							cmd_nxt.cmd = WRITE;
						else
							cmd_nxt.cmd = READ;
					end else if (ar_req_i) begin
						// Refresh starts with PRE-all
						take_ar            = 1'b1;
						cmd_nxt.cmd        = PRE;
						cmd_nxt.a[A10_ALL] = 1'b1;
						state_nxt          = S_AR;
					end else if (req_any && row_open) begin
						// Wrong row open, close just this bank
						take_pre    = 1'b1;
						cmd_nxt.cmd = PRE;
						cmd_nxt.ba  = req_ba;
					end else if (req_any) begin
						take_act    = 1'b1;
						cmd_nxt.cmd = ACT;
						cmd_nxt.ba  = req_ba;
						cmd_nxt.a   = req_row;
					end
				end
			end
			S_AR: begin
				// Second half of the refresh pair
				if (have_credit) begin
					cmd_nxt.cmd = AR;
					state_nxt   = S_IDLE;
				end
			end
			default: state_nxt = S_IDLE;
		endcase
	end

	assign take = (cmd_nxt.cmd != NOP);

	//--------------------
	// State, credits, bank flags
	//--------------------
	always_ff @(posedge clk) begin
		if (reset_int) begin
			state       <= S_INIT;
			credit_cnt  <= CRD_W'(CMD_DEPTH);
			bank_act    <= '0;
			fml_done_o  <= 1'b0;
			init_ack_o  <= 1'b0;
			ar_done_o   <= 1'b0;
			cmd_valid_o <= 1'b0;
		end else begin
			state <= state_nxt;
			// One credit per enqueue, one back per pop
			credit_cnt  <= credit_cnt + CRD_W'(credit_i) - CRD_W'(take);
			fml_done_o  <= take_rw;
			init_ack_o  <= take_init;
			ar_done_o   <= take_ar;
			cmd_valid_o <= take;
			if (take_ar)
				bank_act <= '0;
			if (take_pre)
				bank_act[req_ba] <= 1'b0;
			if (take_act)
				bank_act[req_ba] <= 1'b1;
		end
	end

	// Command word and row table
	always_ff @(posedge clk) begin
		if (take)
			cmd_o <= cmd_nxt;
		if (take_act)
			bank_row[req_ba] <= req_row;
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the DDR controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ddr_ctrl -f list.f -o tb_ddr_ctrl

out=$(./obj_dir/tb_ddr_ctrl 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
